// ==== flist.f ====
+incdir+.
sw_pkg.sv
seq_loader.sv
sync_fifo.sv
sw_pe.sv
sw_scorer.sv
sw_top.sv
tb_sw_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_sw_top -f flist.f -o sim_tb_sw_top
./obj_dir/sim_tb_sw_top | tee sim.log

if grep -q "TEST PASS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== seq_loader.sv ====
// Words must arrive as query then target; lengths above the array size are clipped without notice
`timescale 1ns/100ps
`include "sw_settings.svh"

module seq_loader (
  input  logic              ha_pclock,
  input  logic              reset,
  input  logic              seq_valid,
  input  sw_pkg::seq_word_t seq_word,
  input  logic              little_endian,
  output logic              job_push,
  output sw_pkg::job_t      job
);

  localparam int bases_w = 2 * `SW_TARGET_LEN;
  localparam int qlw     = sw_pkg::query_len_w;
  localparam int tlw     = sw_pkg::target_len_w;

  logic                               index_s;      // Low for query, high for target
  logic [`SW_LEN_W-1:0]               len_swap;     // Byte-reversed length
  logic [`SW_LEN_W-1:0]               len_fix;      // Length in host order
  logic [bases_w-1:0]                 bases_raw;
  logic [bases_w-1:0]                 bases_swap;   // Byte-reversed base field
  sw_pkg::base_t [`SW_TARGET_LEN-1:0] bases_fix;
  logic [qlw-1:0]                     q_len_c;      // Length clipped as a query
  logic [tlw-1:0]                     t_len_c;      // Length clipped as a target
  sw_pkg::base_t [`SW_QUERY_LEN-1:0]  query_q;      // First word of the pair
  logic [qlw-1:0]                     query_len_q;

  assign bases_raw  = seq_word.bases;
  assign len_swap   = {<<8{seq_word.len}};    // Each field swapped on its own
  assign bases_swap = {<<8{bases_raw}};

  always_comb
  begin
    len_fix   = little_endian ? len_swap : seq_word.len;
    bases_fix = little_endian ? bases_swap : bases_raw;
    if (len_fix > `SW_QUERY_LEN)
      q_len_c = qlw'(`SW_QUERY_LEN);              // Array is only this long
    else
      q_len_c = len_fix[qlw-1:0];
    if (len_fix > `SW_TARGET_LEN)
      t_len_c = tlw'(`SW_TARGET_LEN);             // One word of bases at most
    else
      t_len_c = len_fix[tlw-1:0];
  end

  // Pair tracking and push strobe
  always_ff @(posedge ha_pclock)
  begin
    if (reset)
    begin
      index_s  <= 1'b0;
      job_push <= 1'b0;
    end
    else
    begin
      job_push <= seq_valid && index_s;           // One cycle after the target word
      if (seq_valid)
        index_s <= ~index_s;
    end
  end

  // Query hold and job assembly
  always_ff @(posedge ha_pclock)
  begin
    if (seq_valid && !index_s)
    begin
      query_q     <= bases_fix[`SW_QUERY_LEN-1:0];  // Upper bases never reach the array
      query_len_q <= q_len_c;
    end
    if (seq_valid && index_s)
    begin
      job.query      <= query_q;
      job.query_len  <= query_len_q;
      job.target     <= bases_fix;
      job.target_len <= t_len_c;
    end
  end

endmodule

// ==== sw_pe.sv ====
// Scores are unsigned and clipped at zero; gap open is charged for the first base of a gap
`timescale 1ns/100ps
`include "sw_settings.svh"

module sw_pe (
  input  logic                   ha_pclock,
  input  logic                   reset,
  input  logic                   clear,
  input  logic                   active,
  input  sw_pkg::base_t          query_base,
  input  logic                   in_valid,
  input  sw_pkg::base_t          in_base,
  input  logic [`SW_SCORE_W-1:0] in_h,
  input  logic [`SW_SCORE_W-1:0] in_f,
  output logic                   out_valid,
  output sw_pkg::base_t          out_base,
  output logic [`SW_SCORE_W-1:0] out_h,
  output logic [`SW_SCORE_W-1:0] out_f,
  output sw_pkg::result_t        best
);

  typedef logic signed [`SW_SCORE_W+1:0] wide_t;   // Sign bit plus one spare

  logic [`SW_SCORE_W-1:0] h_left;     // Own H for the previous target base
  logic [`SW_SCORE_W-1:0] e_left;     // Own E for the previous target base
  logic [`SW_SCORE_W-1:0] h_diag;     // Upstream H for the previous target base
  logic [`SW_SCORE_W-1:0] e_new;
  logic [`SW_SCORE_W-1:0] f_new;
  logic [`SW_SCORE_W-1:0] h_new;
  wide_t                  sub_score;  // Match or mismatch

  function automatic wide_t widen(input logic [`SW_SCORE_W-1:0] v);
    return wide_t'({2'b00, v});
  endfunction

  function automatic logic [`SW_SCORE_W-1:0] clip0(input wide_t v);
    return (v < 0) ? '0 : v[`SW_SCORE_W-1:0];
  endfunction

  function automatic logic [`SW_SCORE_W-1:0] max_u(input logic [`SW_SCORE_W-1:0] a,
                                                   input logic [`SW_SCORE_W-1:0] b);
    return (a > b) ? a : b;
  endfunction

  // Gotoh cell
  always_comb
  begin
    sub_score = (in_base == query_base) ? wide_t'(`SW_MATCH) : wide_t'(`SW_MISMATCH);
    e_new = max_u(clip0(widen(e_left) + wide_t'(`SW_GAP_EXTEND)),   // Gap along target
                  clip0(widen(h_left) + wide_t'(`SW_GAP_OPEN)));
    f_new = max_u(clip0(widen(in_f) + wide_t'(`SW_GAP_EXTEND)),     // Gap along query
                  clip0(widen(in_h) + wide_t'(`SW_GAP_OPEN)));
    h_new = max_u(clip0(widen(h_diag) + sub_score), max_u(e_new, f_new));
  end

  always_ff @(posedge ha_pclock)
  begin
    if (reset || clear)
      out_valid <= 1'b0;
    else
      out_valid <= in_valid;
  end

  // Values to the next element, inactive ones pass through
  always_ff @(posedge ha_pclock)
  begin
    out_base <= in_base;
    out_h    <= active ? h_new : in_h;
    out_f    <= active ? f_new : in_f;
  end

  // Row state and running maximum
  always_ff @(posedge ha_pclock)
  begin
    if (clear)
    begin
      h_left <= '0;
      e_left <= '0;
      h_diag <= '0;                   // Row above starts at zero
      best   <= '0;
    end
    else if (in_valid && active)
    begin
      h_left <= h_new;
      e_left <= e_new;
      h_diag <= in_h;                 // Diagonal for the next base
      best   <= max_u(best, h_new);
    end
  end

endmodule

// ==== sw_pkg.sv ====
// Job lengths are stored already clipped, so their widths follow the array sizes and not SW_LEN_W
`include "sw_settings.svh"

package sw_pkg;

  localparam int query_len_w  = $clog2(`SW_QUERY_LEN + 1);   // Holds 0 to SW_QUERY_LEN
  localparam int target_len_w = $clog2(`SW_TARGET_LEN + 1);  // Holds 0 to SW_TARGET_LEN

  typedef logic [1:0] base_t;       // A=0 G=1 T=2 C=3

  // Raw host descriptor word
  typedef struct packed {
    logic [`SW_LEN_W-1:0]       len;     // Upper two bytes
    base_t [`SW_TARGET_LEN-1:0] bases;   // Base 0 in the lowest bits
  } seq_word_t;

  // One query/target pair ready for scoring
  typedef struct packed {
    base_t [`SW_QUERY_LEN-1:0]  query;
    logic [query_len_w-1:0]     query_len;
    base_t [`SW_TARGET_LEN-1:0] target;
    logic [target_len_w-1:0]    target_len;
  } job_t;

  typedef logic [`SW_SCORE_W-1:0] result_t;   // Best local score

endpackage

// ==== sw_scorer.sv ====
// One job at a time; a job starts only when the result FIFO has room, so a score is never held
`timescale 1ns/100ps
`include "sw_settings.svh"

module sw_scorer (
  input  logic            ha_pclock,
  input  logic            reset,
  input  logic            job_empty,
  input  sw_pkg::job_t    job,
  output logic            job_pop,
  input  logic            res_full,
  output logic            res_push,
  output sw_pkg::result_t result
);

  localparam int q_len = `SW_QUERY_LEN;
  localparam int qlw   = sw_pkg::query_len_w;
  localparam int tlw   = sw_pkg::target_len_w;

  typedef enum logic [1:0] {
    st_idle,
    st_calculate,
    st_write
  } state_t;

  state_t                 state;
  sw_pkg::job_t           job_q;                // Target field shifts out as bases are fed
  logic [tlw-1:0]         base_cnt;             // Bases sent into the array
  logic [tlw-1:0]         out_cnt;              // Bases out of the last element
  logic                   feed;
  logic                   clear;
  logic                   pe_valid [q_len+1];   // Chain links, index 0 is the input
  sw_pkg::base_t          pe_base  [q_len+1];
  logic [`SW_SCORE_W-1:0] pe_h     [q_len+1];
  logic [`SW_SCORE_W-1:0] pe_f     [q_len+1];
  sw_pkg::result_t        pe_best  [q_len];
  sw_pkg::result_t        max_best;

  assign job_pop  = (state == st_idle) && !job_empty && !res_full;
  assign clear    = job_pop;                    // Array cleared on the pop edge
  assign feed     = (state == st_calculate) && (base_cnt != job_q.target_len);
  assign res_push = (state == st_write);
  assign result   = max_best;

  // Array boundary
  assign pe_valid[0] = feed;
  assign pe_base[0]  = job_q.target[0];
  assign pe_h[0]     = '0;                      // H of row zero
  assign pe_f[0]     = '0;                      // No gap above row one

  generate
    for (genvar i = 0; i < q_len; i++)
    begin : g_pe
      sw_pe u_sw_pe (
        .ha_pclock  (ha_pclock),
        .reset      (reset),
        .clear      (clear),
        .active     (qlw'(i) < job_q.query_len),
        .query_base (job_q.query[i]),
        .in_valid   (pe_valid[i]),
        .in_base    (pe_base[i]),
        .in_h       (pe_h[i]),
        .in_f       (pe_f[i]),
        .out_valid  (pe_valid[i+1]),
        .out_base   (pe_base[i+1]),
        .out_h      (pe_h[i+1]),
        .out_f      (pe_f[i+1]),
        .best       (pe_best[i])
      );
    end
  endgenerate

  // Best over all elements, stable once the array drains
  always_comb
  begin
    max_best = '0;
    for (int i = 0; i < q_len; i++)
      if (pe_best[i] > max_best)
        max_best = pe_best[i];
  end

  always_ff @(posedge ha_pclock)
  begin
    if (reset)
    begin
      state    <= st_idle;
      base_cnt <= '0;
      out_cnt  <= '0;
    end
    else
    begin
      case (state)
        st_idle:
          if (job_pop)
          begin
            base_cnt <= '0;
            out_cnt  <= '0;
            state    <= st_calculate;
          end
        st_calculate:
        begin
          if (feed)
            base_cnt <= base_cnt + 1'b1;
          if (pe_valid[q_len])
            out_cnt <= out_cnt + 1'b1;
          if (out_cnt == job_q.target_len)      // Zero length ends at once
            state <= st_write;
        end
        st_write:
          state <= st_idle;                     // Single push cycle
        default:
          state <= st_idle;
      endcase
    end
  end

  // Job capture and target shift
  always_ff @(posedge ha_pclock)
  begin
    if (job_pop)
      job_q <= job;
    else if (feed)
      job_q.target <= {2'b00, job_q.target[`SW_TARGET_LEN-1:1]};
  end

endmodule

// ==== sw_settings.svh ====
// The 48-bit descriptor word layout holds only while SW_TARGET_LEN stays at 16 and SW_LEN_W at 16
`ifndef SW_SETTINGS_SVH
`define SW_SETTINGS_SVH

// Array and sequence sizes
`define SW_QUERY_LEN 8             // Processing elements, longest query
`define SW_TARGET_LEN 16           // Longest target, also bases per word
`define SW_LEN_W 16                // Descriptor length field width

// Score path
`define SW_SCORE_W 12              // Unsigned, never below zero

// Affine gap scoring, signed values added to a score
`define SW_MATCH 5
`define SW_MISMATCH (-4)
`define SW_GAP_OPEN (-12)          // First base of a gap
`define SW_GAP_EXTEND (-4)         // Each further base of the same gap

// Buffering
`define SW_JOB_DEPTH 2             // Alignment jobs waiting for the scorer
`define SW_RES_DEPTH 2             // Scores waiting for the host

`endif

// ==== sw_top.sv ====
// Host must not strobe seq_valid while seq_full is high; results leave in job order
`timescale 1ns/100ps
`include "sw_settings.svh"

module sw_top (
  input  logic              ha_pclock,
  input  logic              reset,
  input  logic              seq_valid,
  input  sw_pkg::seq_word_t seq_word,
  input  logic              little_endian,
  input  logic              result_ready,
  output logic              seq_full,
  output logic              result_valid,
  output sw_pkg::result_t   result_data
);

  logic            job_push;
  logic            job_pop;
  logic            job_empty;
  sw_pkg::job_t    job_in;     // Loader to job FIFO
  sw_pkg::job_t    job_head;   // Job FIFO to scorer
  logic            res_push;
  logic            res_empty;
  logic            res_full;
  sw_pkg::result_t res_in;

  assign result_valid = result_ready && !res_empty;   // Also pops the result FIFO

  seq_loader u_seq_loader (
    .ha_pclock     (ha_pclock),
    .reset         (reset),
    .seq_valid     (seq_valid),
    .seq_word      (seq_word),
    .little_endian (little_endian),
    .job_push      (job_push),
    .job           (job_in)
  );

  sync_fifo #(
    .payload_t (sw_pkg::job_t),
    .depth     (`SW_JOB_DEPTH)
  ) u_job_fifo (
    .ha_pclock (ha_pclock),
    .reset     (reset),
    .push      (job_push),
    .push_data (job_in),
    .pop       (job_pop),
    .pop_data  (job_head),
    .empty     (job_empty),
    .full      (seq_full)          // Back-pressure straight to the host
  );

  sw_scorer u_sw_scorer (
    .ha_pclock (ha_pclock),
    .reset     (reset),
    .job_empty (job_empty),
    .job       (job_head),
    .job_pop   (job_pop),
    .res_full  (res_full),
    .res_push  (res_push),
    .result    (res_in)
  );

  sync_fifo #(
    .payload_t (sw_pkg::result_t),
    .depth     (`SW_RES_DEPTH)
  ) u_res_fifo (
    .ha_pclock (ha_pclock),
    .reset     (reset),
    .push      (res_push),
    .push_data (res_in),
    .pop       (result_valid),
    .pop_data  (result_data),
    .empty     (res_empty),
    .full      (res_full)
  );

endmodule

// ==== sync_fifo.sv ====
// Push while full is dropped and pop while empty is ignored; the head is read without a clock
`timescale 1ns/100ps

module sync_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = 2
) (
  input  logic     ha_pclock,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty,
  output logic     full
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];   // Circular storage
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;         // Entries held
  logic             do_push;
  logic             do_pop;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;   // Wraps at depth
  endfunction

  assign empty    = (count == '0);
  assign full     = (count == cnt_w'(depth));
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign pop_data = mem[rd_ptr];   // Head visible the cycle after its push

  always_ff @(posedge ha_pclock)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= next_ptr(wr_ptr);
      if (do_pop)
        rd_ptr <= next_ptr(rd_ptr);
      count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
    end
  end

  always_ff @(posedge ha_pclock)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

endmodule

// ==== tb_sw_top.sv ====
// Assumes SW_QUERY_LEN 8, SW_TARGET_LEN 16 and 2-deep FIFOs; stops at the first wrong result
`timescale 1ns/100ps
`include "sw_settings.svh"

module tb_sw_top;

  localparam int n_random    = 40;
  localparam int n_little    = 20;
  localparam int bp_max      = 8;                 // Pairs tried before seq_full must rise
  localparam int bp_wait     = 60;                // Cycles per pair to see seq_full
  localparam int bp_release  = 40;                // Extra hold with result_ready low
  localparam int n_jobs      = 1 + n_random + n_little + bp_max + 2;
  localparam int bp_hold     = bp_max * bp_wait + bp_release;
  localparam int cycle_limit = n_jobs * (`SW_TARGET_LEN + `SW_QUERY_LEN + 10) + bp_hold + 200;

  logic              ha_pclock;
  logic              reset;
  logic              seq_valid;
  sw_pkg::seq_word_t seq_word;
  logic              little_endian;
  logic              result_ready;
  logic              seq_full;
  logic              result_valid;
  sw_pkg::result_t   result_data;

  sw_pkg::result_t exp_q [$];                     // Expected scores in job order
  logic [31:0]     lfsr_state;
  int              cycle_cnt;
  int              results_seen;

  sw_top u_sw_top (
    .ha_pclock     (ha_pclock),
    .reset         (reset),
    .seq_valid     (seq_valid),
    .seq_word      (seq_word),
    .little_endian (little_endian),
    .result_ready  (result_ready),
    .seq_full      (seq_full),
    .result_valid  (result_valid),
    .result_data   (result_data)
  );

  initial
  begin
    ha_pclock = 1'b0;
    forever #4 ha_pclock = ~ha_pclock;            // 8 ns period
  end

  // Taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);        // One step per bit
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  function automatic int max3(input int a, input int b, input int c);
    int m;
    m = (a > b) ? a : b;
    return (m > c) ? m : c;
  endfunction

  // Gotoh local alignment, every cell clipped at zero
  function automatic sw_pkg::result_t ref_score(input sw_pkg::base_t [`SW_QUERY_LEN-1:0] q,
                                                input int qlen,
                                                input sw_pkg::base_t [`SW_TARGET_LEN-1:0] t,
                                                input int tlen);
    int h_up [`SW_QUERY_LEN+1];                   // Row for the previous target base
    int h_row [`SW_QUERY_LEN+1];
    int e [`SW_QUERY_LEN+1];
    int f;
    int s;
    int best;
    best = 0;
    for (int i = 0; i <= `SW_QUERY_LEN; i++)
    begin
      h_up[i]  = 0;
      h_row[i] = 0;
      e[i]     = 0;
    end
    for (int j = 0; j < tlen; j++)
    begin
      h_row[0] = 0;
      f = 0;                                      // No vertical gap into query base 1
      for (int i = 1; i <= qlen; i++)
      begin
        s = (q[i-1] == t[j]) ? `SW_MATCH : `SW_MISMATCH;
        e[i] = max3(e[i] + `SW_GAP_EXTEND, h_up[i] + `SW_GAP_OPEN, 0);
        f = max3(f + `SW_GAP_EXTEND, h_row[i-1] + `SW_GAP_OPEN, 0);
        h_row[i] = max3(h_up[i-1] + s, e[i], f);  // E and F never below zero
        if (h_row[i] > best)
          best = h_row[i];
      end
      for (int i = 0; i <= qlen; i++)
        h_up[i] = h_row[i];
    end
    return sw_pkg::result_t'(best);
  endfunction

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_result(input sw_pkg::result_t exp, input sw_pkg::result_t act);
    if (act !== exp)
      report_fail($sformatf("mismatch result_data expected %h actual %h", exp, act));
  endtask

  // Byte order as a little-endian host would send it
  function automatic sw_pkg::seq_word_t to_little(input sw_pkg::seq_word_t w);
    logic [31:0]       b;
    sw_pkg::seq_word_t r;
    b = w.bases;
    r.len   = {w.len[7:0], w.len[15:8]};
    r.bases = {b[7:0], b[15:8], b[23:16], b[31:24]};
    return r;
  endfunction

  // Called on a falling edge, returns on a falling edge
  task automatic send_word(input sw_pkg::seq_word_t w);
    while (seq_full)
      @(negedge ha_pclock);
    seq_word  = w;
    seq_valid = 1'b1;
    @(negedge ha_pclock);
    seq_valid = 1'b0;
  endtask

  task automatic idle_gap();
    logic [31:0] g;
    take_bits(2, g);
    repeat (int'(g)) @(negedge ha_pclock);       // 0 to 3 idle cycles
  endtask

  task automatic queue_pair(input sw_pkg::seq_word_t qw, input sw_pkg::seq_word_t tw,
                            input logic le, input sw_pkg::result_t exp);
    exp_q.push_back(exp);
    idle_gap();
    send_word(le ? to_little(qw) : qw);
    idle_gap();                                   // Query held across idle cycles
    send_word(le ? to_little(tw) : tw);
  endtask

  task automatic random_pair(input int qlen, input int tlen, input logic le);
    sw_pkg::seq_word_t qw;
    sw_pkg::seq_word_t tw;
    logic [31:0]       v;
    take_bits(32, v);
    qw.bases = v;
    take_bits(32, v);
    tw.bases = v;
    qw.len = 16'(qlen);
    tw.len = 16'(tlen);
    queue_pair(qw, tw, le, ref_score(qw.bases[`SW_QUERY_LEN-1:0], qlen, tw.bases, tlen));
  endtask

  task automatic random_lengths(output int qlen, output int tlen);
    logic [31:0] v;
    take_bits(3, v);
    qlen = int'(v) + 1;                           // 1 to 8
    take_bits(4, v);
    tlen = int'(v) + 1;                           // 1 to 16
  endtask

  task automatic drain_results();
    while (exp_q.size() != 0)
      @(negedge ha_pclock);
  endtask

  // Scoreboard and protocol monitor
  initial
  begin : monitor
    sw_pkg::result_t exp;
    forever
    begin
      @(posedge ha_pclock);
      if (!reset)
      begin
        if (seq_valid && seq_full)
          report_fail("seq_valid was strobed while seq_full was high");
        if (result_valid)
        begin
          if (exp_q.size() == 0)
            report_fail("result_valid pulsed with no job outstanding");
          else
          begin
            exp = exp_q.pop_front();
            check_result(exp, result_data);
            results_seen++;
          end
        end
      end
    end
  end

  initial
  begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge ha_pclock);
      cycle_cnt++;
    end
    report_fail($sformatf("run did not finish within %0d cycles", cycle_limit));
  end

  initial
  begin : stimulus
    sw_pkg::seq_word_t w;
    sw_pkg::seq_word_t tw;
    logic [31:0]       v;
    int                ql;
    int                tl;
    int                pairs;
    int                waited;
    int                seen_before;
    seq_valid     = 1'b0;
    seq_word      = '0;
    little_endian = 1'b0;
    result_ready  = 1'b1;
    reset         = 1'b1;
    results_seen  = 0;
    lfsr_state    = 32'h87fa_f5d3;
    repeat (8) @(negedge ha_pclock);
    reset = 1'b0;
    @(negedge ha_pclock);

    take_bits(32, v);                             // Query equals target, full length
    w.len   = 16'd8;
    w.bases = v;
    queue_pair(w, w, 1'b0, sw_pkg::result_t'(`SW_MATCH * 8));

    for (int i = 0; i < n_random; i++)
    begin
      if (i == 0)
      begin
        ql = 1;
        tl = 1;
      end
      else if (i == 1)
      begin
        ql = `SW_QUERY_LEN;
        tl = `SW_TARGET_LEN;
      end
      else
        random_lengths(ql, tl);
      random_pair(ql, tl, 1'b0);
    end

    little_endian = 1'b1;                         // Held for all words of the block
    for (int i = 0; i < n_little; i++)
    begin
      random_lengths(ql, tl);
      random_pair(ql, tl, 1'b1);
    end
    little_endian = 1'b0;
    drain_results();

    result_ready = 1'b0;                          // Back-pressure from the host
    seen_before  = results_seen;
    pairs        = 0;
    while (!seq_full && pairs < bp_max)
    begin
      random_lengths(ql, tl);
      random_pair(ql, tl, 1'b0);
      pairs++;
      waited = 0;
      while (!seq_full && waited < bp_wait)
      begin
        @(negedge ha_pclock);
        waited++;
      end
    end
    if (!seq_full)
      report_fail("seq_full did not rise while result_ready was held low");
    repeat (bp_release) @(negedge ha_pclock);
    if (results_seen != seen_before)
      report_fail("a result left while result_ready was low");
    result_ready = 1'b1;
    drain_results();

    take_bits(32, v);                             // Empty target
    w.len    = 16'd8;
    w.bases  = v;
    take_bits(32, v);
    tw.len   = 16'd0;
    tw.bases = v;
    queue_pair(w, tw, 1'b0, '0);
    random_lengths(ql, tl);
    random_pair(ql, tl, 1'b0);
    drain_results();
    repeat (4) @(negedge ha_pclock);

    $display("TEST PASS");
    $finish;
  end

endmodule
